// ==== src/vic_pkg.sv ====
package vic_pkg;

    // ------------------------------------------------------------------
    // chip selection and width types
    // ------------------------------------------------------------------

    // CHIP_UNUSED is handled like the 6569
    typedef enum logic [1:0] {
        CHIP_6567R8   = 2'd0,
        CHIP_6567R56A = 2'd1,
        CHIP_6569     = 2'd2,
        CHIP_UNUSED   = 2'd3
    } chip_t;

    typedef logic [9:0] raster_x_t;
    typedef logic [8:0] raster_line_t;
    typedef logic [6:0] cycle_num_t;
    typedef logic [3:0] phase_idx_t;
    typedef logic [5:0] reg_addr_t;
    typedef logic [7:0] vic_data_t;

    // ------------------------------------------------------------------
    // timing and bus bundles
    // ------------------------------------------------------------------

    // dot_tick marks the last clk_dot4x tick of a pixel
    typedef struct packed {
        logic       phi;
        phase_idx_t phase_idx;
        logic       dot_tick;
    } phase_t;

    typedef struct packed {
        raster_x_t    raster_x;
        cycle_num_t   cycle_num;
        raster_line_t raster_line;
        logic         line_start;
    } raster_t;

    typedef struct packed {
        logic      ce;
        logic      rw;
        reg_addr_t adi;
        vic_data_t dbi;
    } cpu_bus_t;

    typedef struct packed {
        logic       den;
        logic [2:0] yscroll;
    } vic_ctrl_t;

    // ------------------------------------------------------------------
    // constants
    // ------------------------------------------------------------------

    localparam int PHASE_TICKS = 16;
    // cpu write data is stable at this point of PHI high
    localparam phase_idx_t PHASE_DATA_DAV = 4'd12;

    localparam raster_x_t    PIXELS_R8   = 10'd520;
    localparam raster_line_t LINES_R8    = 9'd263;
    localparam raster_x_t    PIXELS_R56A = 10'd512;
    localparam raster_line_t LINES_R56A  = 9'd262;
    localparam raster_x_t    PIXELS_6569 = 10'd504;
    localparam raster_line_t LINES_6569  = 9'd312;

    localparam raster_line_t BADLINE_FIRST = 9'd48;
    localparam raster_line_t BADLINE_END   = 9'd248;

    localparam cycle_num_t BA_CHAR_FIRST_CYCLE = 7'd12;
    localparam cycle_num_t BA_CHAR_LAST_CYCLE  = 7'd54;

    localparam reg_addr_t REG_CTRL1     = 6'h11;
    localparam reg_addr_t REG_RASTER    = 6'h12;
    localparam reg_addr_t REG_IRQ_LATCH = 6'h19;
    localparam reg_addr_t REG_IRQ_EN    = 6'h1A;

endpackage

// ==== src/phase_gen.sv ====
`timescale 1ns/1ns

module phase_gen
    import vic_pkg::*;
(
    input  logic   clk_dot4x,
    input  logic   rst,
    output phase_t phase_o
);

    // rotating PHI pattern, bit 0 is the current PHI level
    logic [31:0] phi_gen;
    // position within the full PHI period, 0 to 31
    logic [4:0]  tick_cnt;

    // ------------------------------------------------------------------
    // PHI pattern
    // ------------------------------------------------------------------

    // low half first so PHI starts low out of reset
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phi_gen <= 32'hFFFF_0000;
        end else begin
            phi_gen <= {phi_gen[0], phi_gen[31:1]};
        end
    end

    // tick counter, wraps once per PHI period
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            tick_cnt <= '0;
        end else if (tick_cnt == 5'(2 * PHASE_TICKS - 1)) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 5'd1;
        end
    end

    // half-phase index restarts at every PHI edge
    assign phase_o.phi       = phi_gen[0];
    assign phase_o.phase_idx = tick_cnt[3:0];
    // four ticks per pixel, last one closes the pixel
    assign phase_o.dot_tick  = (tick_cnt[1:0] == 2'd3);

endmodule

// ==== src/raster_counter.sv ====
`timescale 1ns/1ns

module raster_counter
    import vic_pkg::*;
(
    input  logic    clk_dot4x,
    input  logic    rst,
    input  chip_t   chip_i,
    input  phase_t  phase_i,
    output raster_t raster_o
);

    raster_x_t    pixels;
    raster_line_t lines;
    raster_x_t    raster_x;
    raster_line_t raster_line;

    // ------------------------------------------------------------------
    // per-chip line geometry
    // ------------------------------------------------------------------
    always_comb begin
        case (chip_i)
            CHIP_6567R8: begin
                pixels = PIXELS_R8;
                lines  = LINES_R8;
            end
            CHIP_6567R56A: begin
                pixels = PIXELS_R56A;
                lines  = LINES_R56A;
            end
            // 6569 and the spare encoding
            default: begin
                pixels = PIXELS_6569;
                lines  = LINES_6569;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // beam position
    // ------------------------------------------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x    <= '0;
            raster_line <= '0;
        end else if (phase_i.dot_tick) begin
            if (raster_x == pixels - 10'd1) begin
                raster_x <= '0;
                // end of line, step or wrap the frame
                if (raster_line == lines - 9'd1) begin
                    raster_line <= '0;
                end else begin
                    raster_line <= raster_line + 9'd1;
                end
            end else begin
                raster_x <= raster_x + 10'd1;
            end
        end
    end

    assign raster_o.raster_x    = raster_x;
    // eight pixels per cycle
    assign raster_o.cycle_num   = raster_x[9:3];
    assign raster_o.raster_line = raster_line;
    // pixel 0 always begins at PHI low index 0
    assign raster_o.line_start  = (raster_x == '0) && !phase_i.phi &&
                                  (phase_i.phase_idx == '0);

endmodule

// ==== src/badline_detect.sv ====
`timescale 1ns/1ns

module badline_detect
    import vic_pkg::*;
(
    input  logic      clk_dot4x,
    input  logic      rst,
    input  phase_t    phase_i,
    input  raster_t   raster_i,
    input  vic_ctrl_t ctrl_i,
    output logic      badline_o
);

    // permission to fetch characters this frame
    logic allow_bad;
    logic allow_bad_nxt;
    logic in_window;
    logic eval;

    // once per cycle, early in PHI low
    assign eval = !phase_i.phi && (phase_i.phase_idx == 4'd1);

    // display window lines 48 to 247
    assign in_window = (raster_i.raster_line >= BADLINE_FIRST) &&
                       (raster_i.raster_line < BADLINE_END);

    // den only counts while the beam is on line 48
    always_comb begin
        allow_bad_nxt = allow_bad;
        if (ctrl_i.den && (raster_i.raster_line == BADLINE_FIRST)) begin
            allow_bad_nxt = 1'b1;
        end
        if (raster_i.raster_line == BADLINE_END) begin
            allow_bad_nxt = 1'b0;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow_bad <= 1'b0;
            badline_o <= 1'b0;
        end else if (eval) begin
            allow_bad <= allow_bad_nxt;
            // held for the rest of the cycle
            badline_o <= allow_bad_nxt && in_window &&
                         (raster_i.raster_line[2:0] == ctrl_i.yscroll);
        end
    end

endmodule

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter
    import vic_pkg::*;
(
    input  logic     clk_dot4x,
    input  logic     rst,
    input  phase_t   phase_i,
    input  raster_t  raster_i,
    input  logic     badline_i,
    input  cpu_bus_t cpu_i,
    output logic     ba_o,
    output logic     aec_o,
    output logic     vic_write_db_o,
    output logic     vic_write_ab_o
);

    logic ba_req;
    logic phi_end;
    logic phi_nxt;
    // ba history over the last three PHI-high ends
    logic ba1;
    logic ba2;
    logic ba3;
    // aec delay line for the address drivers
    logic aec2;
    logic aec3;

    // ------------------------------------------------------------------
    // BA for character fetches
    // ------------------------------------------------------------------
    assign ba_req = badline_i &&
                    (raster_i.cycle_num >= BA_CHAR_FIRST_CYCLE) &&
                    (raster_i.cycle_num <= BA_CHAR_LAST_CYCLE);

    // ba active low, one clock behind the request
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_o <= 1'b0;
        end else begin
            ba_o <= !ba_req;
        end
    end

    // last tick of PHI high
    assign phi_end = phase_i.phi && (phase_i.phase_idx == 4'(PHASE_TICKS - 1));

    // cpu keeps three more PHI-high cycles after ba falls
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba1 <= 1'b1;
            ba2 <= 1'b1;
            ba3 <= 1'b1;
        end else if (phi_end) begin
            ba1 <= ba_o;
            ba2 <= ba1 | ba_o;
            ba3 <= ba2 | ba_o;
        end
    end

    // ------------------------------------------------------------------
    // AEC and bus direction
    // ------------------------------------------------------------------

    // PHI level on the next tick, keeps aec aligned with phi
    assign phi_nxt = (phase_i.phase_idx == 4'(PHASE_TICKS - 1)) ? !phase_i.phi : phase_i.phi;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            aec_o <= 1'b0;
            aec2  <= 1'b0;
            aec3  <= 1'b0;
        end else begin
            aec_o <= ba_o ? phi_nxt : (ba3 & phi_nxt);
            aec2  <= aec_o;
            aec3  <= aec2;
        end
    end

    // cpu reading one of our registers
    assign vic_write_db_o = cpu_i.rw && !cpu_i.ce;
    // drive address two ticks after aec falls, release with aec rise
    assign vic_write_ab_o = !(aec_o | aec3);

endmodule

// ==== src/vic_registers.sv ====
`timescale 1ns/1ns

module vic_registers
    import vic_pkg::*;
(
    input  logic      clk_dot4x,
    input  logic      rst,
    input  phase_t    phase_i,
    input  raster_t   raster_i,
    input  cpu_bus_t  cpu_i,
    output vic_ctrl_t ctrl_o,
    output vic_data_t dbo_o,
    output logic      irq_o
);

    // $11 bits 0 to 6, bit 7 lives in the compare value
    logic [6:0]   ctrl1;
    raster_line_t raster_cmp;
    vic_data_t    irq_en;
    // raster interrupt latch and per-line fired flag
    logic         irst;
    logic         irst_fired;
    logic         wr_stb;
    logic         cmp_stb;

    // ------------------------------------------------------------------
    // cpu writes
    // ------------------------------------------------------------------

    // sample data late in PHI high
    assign wr_stb = phase_i.phi && (phase_i.phase_idx == PHASE_DATA_DAV) &&
                    !cpu_i.ce && !cpu_i.rw;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ctrl1      <= '0;
            raster_cmp <= '0;
            irq_en     <= '0;
        end else if (wr_stb) begin
            case (cpu_i.adi)
                REG_CTRL1: begin
                    ctrl1         <= cpu_i.dbi[6:0];
                    raster_cmp[8] <= cpu_i.dbi[7];
                end
                REG_RASTER: raster_cmp[7:0] <= cpu_i.dbi;
                REG_IRQ_EN: irq_en <= cpu_i.dbi;
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // raster interrupt
    // ------------------------------------------------------------------
    assign cmp_stb = !phase_i.phi && (phase_i.phase_idx == 4'd8);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irst       <= 1'b0;
            irst_fired <= 1'b0;
        end else begin
            // re-arm at every new line
            if (raster_i.line_start) begin
                irst_fired <= 1'b0;
            end else if (cmp_stb && !irst_fired &&
                         (raster_i.raster_line == raster_cmp)) begin
                irst_fired <= 1'b1;
                irst       <= 1'b1;
            end
            // writing 1 to $19 bit 0 acknowledges
            if (wr_stb && (cpu_i.adi == REG_IRQ_LATCH) && cpu_i.dbi[0]) begin
                irst <= 1'b0;
            end
        end
    end

    // latch counts even while disabled
    assign irq_o = irst & irq_en[0];

    // ------------------------------------------------------------------
    // reads and control outputs
    // ------------------------------------------------------------------
    always_comb begin
        case (cpu_i.adi)
            REG_CTRL1:     dbo_o = {raster_i.raster_line[8], ctrl1};
            REG_RASTER:    dbo_o = raster_i.raster_line[7:0];
            // unused latch bits 6:4 read as ones
            REG_IRQ_LATCH: dbo_o = {irq_o, 3'b111, 3'b000, irst};
            REG_IRQ_EN:    dbo_o = irq_en;
            default:       dbo_o = 8'hFF;
        endcase
    end

    assign ctrl_o.den     = ctrl1[4];
    assign ctrl_o.yscroll = ctrl1[2:0];

endmodule

// ==== src/vic_top.sv ====
`timescale 1ns/1ns

module vic_top
    import vic_pkg::*;
(
    input  logic      clk_dot4x,
    input  logic      rst,
    input  chip_t     chip_i,
    input  logic      ce_i,
    input  logic      rw_i,
    input  reg_addr_t adi_i,
    input  vic_data_t dbi_i,
    output logic      clk_phi_o,
    output vic_data_t dbo_o,
    output logic      irq_o,
    output logic      ba_o,
    output logic      aec_o,
    output logic      vic_write_db_o,
    output logic      vic_write_ab_o
);

    phase_t    phase;
    raster_t   raster;
    vic_ctrl_t ctrl;
    cpu_bus_t  cpu;
    // character fetch demand on the system bus
    logic      badline;

    // cpu side pins into one bundle
    assign cpu.ce  = ce_i;
    assign cpu.rw  = rw_i;
    assign cpu.adi = adi_i;
    assign cpu.dbi = dbi_i;

    assign clk_phi_o = phase.phi;

    // ------------------------------------------------------------------
    // timing core
    // ------------------------------------------------------------------
    phase_gen u_phase_gen (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_o   (phase)
    );

    raster_counter u_raster_counter (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip_i    (chip_i),
        .phase_i   (phase),
        .raster_o  (raster)
    );

    // ------------------------------------------------------------------
    // bus peers and arbiter
    // ------------------------------------------------------------------
    badline_detect u_badline_detect (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_i   (phase),
        .raster_i  (raster),
        .ctrl_i    (ctrl),
        .badline_o (badline)
    );

    vic_registers u_vic_registers (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_i   (phase),
        .raster_i  (raster),
        .cpu_i     (cpu),
        .ctrl_o    (ctrl),
        .dbo_o     (dbo_o),
        .irq_o     (irq_o)
    );

    bus_arbiter u_bus_arbiter (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .phase_i        (phase),
        .raster_i       (raster),
        .badline_i      (badline),
        .cpu_i          (cpu),
        .ba_o           (ba_o),
        .aec_o          (aec_o),
        .vic_write_db_o (vic_write_db_o),
        .vic_write_ab_o (vic_write_ab_o)
    );

endmodule

// ==== tests/vic_asserts.sv ====
`timescale 1ns/1ns

module vic_asserts
    import vic_pkg::*;
(
    input logic   clk_dot4x,
    input logic   rst,
    input phase_t phase_i,
    input logic   ba_o,
    input logic   aec_o
);

    // ba_o seen at the last three PHI-high ends, bit 0 newest
    logic [2:0] ba_ends;
    logic       phi_end;
    // three warning cycles done and BA still low
    logic       bus_taken;

    assign phi_end   = phase_i.phi && (phase_i.phase_idx == 4'(PHASE_TICKS - 1));
    assign bus_taken = !ba_o && (ba_ends == 3'b000);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_ends <= '1;
        end else if (phi_end) begin
            ba_ends <= {ba_ends[1:0], ba_o};
        end
    end

    // aec never outruns PHI
    aec_low_in_phi_low: assert property (@(posedge clk_dot4x) disable iff (rst)
        !phase_i.phi |-> !aec_o)
        else $error("aec_o high while PHI low");

    // VIC takes PHI high only after three PHI-high ends of BA low
    aec_needs_ba_history: assert property (@(posedge clk_dot4x) disable iff (rst)
        (phase_i.phi && !aec_o) |-> $past(bus_taken))
        else $error("aec_o low in PHI high without BA history");

    // once the warning has run out the cpu loses PHI high
    aec_taken_after_history: assert property (@(posedge clk_dot4x) disable iff (rst)
        (phase_i.phi && $past(bus_taken)) |-> !aec_o)
        else $error("aec_o high in PHI high after three BA-low PHI ends");

endmodule

bind bus_arbiter vic_asserts u_vic_asserts (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .phase_i   (phase_i),
    .ba_o      (ba_o),
    .aec_o     (aec_o)
);

// ==== tests/tb_vic.sv ====
`timescale 1ns/1ns

module tb_vic
    import vic_pkg::*;
;

    // planned run length in frames, sized to cover every test below
    localparam int     PLAN_FRAMES = 8;
    localparam longint WATCHDOG_NS = 2 * PLAN_FRAMES * 312 * 504 * 4 * 20;

    logic      clk_dot4x;
    logic      rst;
    chip_t     chip;
    logic      ce;
    logic      rw;
    reg_addr_t adi;
    vic_data_t dbi;
    logic      clk_phi;
    vic_data_t dbo;
    logic      irq;
    logic      ba;
    logic      aec;
    logic      write_db;
    logic      write_ab;

    int        errors;
    int        checks;
    int        clk_cnt;
    int        ba_falls;
    int        irq_rises;
    int        irq_rise_clk;
    logic      ba_high_phase;
    logic      phi_prev;
    logic      aec_h1;
    logic      aec_h2;
    logic      ba_prev;
    logic      irq_prev;
    logic      aec_seen;
    logic      ba_armed;

    vic_top uut (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .chip_i         (chip),
        .ce_i           (ce),
        .rw_i           (rw),
        .adi_i          (adi),
        .dbi_i          (dbi),
        .clk_phi_o      (clk_phi),
        .dbo_o          (dbo),
        .irq_o          (irq),
        .ba_o           (ba),
        .aec_o          (aec),
        .vic_write_db_o (write_db),
        .vic_write_ab_o (write_ab)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #10 clk_dot4x = ~clk_dot4x;
    end

    always @(posedge clk_dot4x) clk_cnt++;

    // ------------------------------------------------------------------
    // reference model and check helpers
    // ------------------------------------------------------------------

    // frame length in clocks and badline count from the chip geometry
    function automatic void frame_ref(input chip_t c, input int ys,
                                      output int clocks, output int badlines);
        int pix;
        int lin;
        pix = (c == CHIP_6567R8) ? 520 : (c == CHIP_6567R56A) ? 512 : 504;
        lin = (c == CHIP_6567R8) ? 263 : (c == CHIP_6567R56A) ? 262 : 312;
        clocks = pix * lin * 4;
        badlines = 0;
        for (int l = 48; l < 248; l++) begin
            if ((l % 8) == ys) badlines++;
        end
    endfunction

    task automatic check_value(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("[ERROR] %0t ns: %s", $time, msg);
        end
    endtask

    // ------------------------------------------------------------------
    // bus monitor for ba, aec and irq
    // ------------------------------------------------------------------
    always @(negedge clk_dot4x) begin
        if (rst) begin
            ba_prev       = 1'b0;
            irq_prev      = 1'b0;
            ba_armed      = 1'b0;
            aec_seen      = 1'b0;
            ba_high_phase = 1'b0;
            phi_prev      = 1'b0;
            aec_h1        = 1'b0;
            aec_h2        = 1'b0;
        end else begin
            if (ba_prev && !ba) begin
                ba_falls++;
                aec_seen = 1'b0;
                ba_armed = 1'b1;
            end
            if (!ba && clk_phi && !aec) aec_seen = 1'b1;
            if (!ba_prev && ba && ba_armed) begin
                check_value(aec_seen, "aec_o never low in PHI high during ba_o low");
            end
            // ba_o high since this PHI-high phase began
            if (clk_phi && !phi_prev) begin
                ba_high_phase = ba;
            end else begin
                ba_high_phase = ba_high_phase && ba;
            end
            if (clk_phi && ba_high_phase) begin
                check_value(aec, "aec_o low in PHI high while ba_o high");
            end
            // address drivers on from the third clock of aec low
            check_value(write_ab == (!aec && !aec_h1 && !aec_h2),
                        "vic_write_ab_o does not follow aec_o two clocks late");
            aec_h2 = aec_h1;
            aec_h1 = aec;
            if (!irq_prev && irq) begin
                irq_rises++;
                irq_rise_clk = clk_cnt;
            end
            ba_prev  = ba;
            irq_prev = irq;
            phi_prev = clk_phi;
        end
    end

    // ------------------------------------------------------------------
    // cpu bus tasks
    // ------------------------------------------------------------------

    // start of PHI high, held past the data sample point
    task automatic write_reg(input reg_addr_t a, input vic_data_t d);
        @(posedge clk_phi);
        @(negedge clk_dot4x);
        ce  = 1'b0;
        rw  = 1'b0;
        adi = a;
        dbi = d;
        repeat (14) @(negedge clk_dot4x);
        ce = 1'b1;
        rw = 1'b1;
    endtask

    task automatic read_check(input reg_addr_t a, input vic_data_t mask,
                              input vic_data_t exp);
        @(negedge clk_dot4x);
        ce  = 1'b0;
        rw  = 1'b1;
        adi = a;
        @(negedge clk_dot4x);
        check_value((dbo & mask) == (exp & mask), $sformatf(
                    "reg %02h read %02h expected %02h", a, dbo, exp));
        check_value(write_db, "vic_write_db_o low during a read");
        ce = 1'b1;
    endtask

    task automatic wait_irq(input int target, input int limit);
        int n;
        n = 0;
        while (irq_rises < target && n < limit) begin
            @(negedge clk_dot4x);
            n++;
        end
        if (irq_rises < target) begin
            errors++;
            $display("timed out waiting for irq_o to rise at %0t ns", $time);
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial begin
        int        fclk;
        int        nbad;
        int        ys;
        int        n;
        int        t1;
        logic      p;
        vic_data_t v;
        raster_line_t cmp;
        void'($urandom(61630));
        errors    = 0;
        checks    = 0;
        clk_cnt   = 0;
        ba_falls  = 0;
        irq_rises = 0;
        rst  = 1'b1;
        ce   = 1'b1;
        rw   = 1'b1;
        adi  = '0;
        dbi  = '0;
        chip = chip_t'(2'($urandom % 3));
        repeat (4) @(negedge clk_dot4x);
        rst = 1'b0;
        frame_ref(chip, 0, fclk, nbad);

        // PHI starts low, 16 clocks per half
        check_value(!clk_phi, "clk_phi_o high after reset");
        for (int i = 0; i < 4; i++) begin
            n = 0;
            p = clk_phi;
            do begin
                @(negedge clk_dot4x);
                n++;
            end while (clk_phi == p);
            check_value(n == 16, $sformatf("PHI half period %0d clocks", n));
        end

        // register read-back
        for (int i = 0; i < 4; i++) begin
            v = 8'($urandom) & 8'h7F;
            write_reg(REG_CTRL1, v);
            read_check(REG_CTRL1, 8'h7F, v);
            v = 8'($urandom);
            write_reg(REG_RASTER, v);
            write_reg(REG_IRQ_EN, v);
            read_check(REG_IRQ_EN, 8'hFF, v);
        end

        // latch counts with the enable clear
        cmp = 9'($urandom % 200);
        write_reg(REG_CTRL1, 8'h00);
        write_reg(REG_RASTER, cmp[7:0]);
        write_reg(REG_IRQ_EN, 8'h00);
        write_reg(REG_IRQ_LATCH, 8'h01);
        n = irq_rises;
        repeat (fclk + 64) @(negedge clk_dot4x);
        check_value(irq_rises == n && !irq, "irq_o raised while disabled");
        write_reg(REG_IRQ_EN, 8'h01);
        check_value(irq, "irq_o not raised by enabling a set latch");
        write_reg(REG_IRQ_LATCH, 8'h01);
        check_value(!irq, "irq_o not cleared by $19 write");

        // raster interrupt spacing is one frame
        n = irq_rises;
        wait_irq(n + 1, 2 * fclk);
        t1 = irq_rise_clk;
        write_reg(REG_IRQ_LATCH, 8'h01);
        wait_irq(n + 2, 2 * fclk);
        check_value(irq_rise_clk - t1 == fclk, $sformatf(
                    "irq spacing %0d clocks expected %0d", irq_rise_clk - t1, fclk));
        write_reg(REG_IRQ_EN, 8'h00);

        // badlines with DEN set, then none with DEN clear
        ys = int'($urandom % 8);
        frame_ref(chip, ys, fclk, nbad);
        write_reg(REG_CTRL1, 8'h10 | 8'(ys));
        repeat (fclk) @(negedge clk_dot4x);
        n = ba_falls;
        repeat (fclk) @(negedge clk_dot4x);
        check_value(ba_falls - n == nbad, $sformatf(
                    "%0d ba_o intervals expected %0d", ba_falls - n, nbad));
        write_reg(REG_CTRL1, 8'(ys));
        repeat (fclk) @(negedge clk_dot4x);
        n = ba_falls;
        repeat (fclk) @(negedge clk_dot4x);
        check_value(ba_falls == n, "ba_o intervals with DEN clear");

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
src/vic_pkg.sv
src/phase_gen.sv
src/raster_counter.sv
src/badline_detect.sv
src/bus_arbiter.sv
src/vic_registers.sv
src/vic_top.sv
tests/vic_asserts.sv
tests/tb_vic.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_vic -f verilog.f -o vsim
	./obj_dir/vsim | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
